// ==== src.f ====
rab_pkg.sv
rab_if.sv
rab_lookup.sv
rab_miss_fifo.sv
rab_cfg_regs.sv
rab_core.sv
rab_core_assert.sv
tb_rab_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_rab_core \
    -f src.f -o sim_tb_rab_core &&
  ./obj_dir/sim_tb_rab_core | tee /dev/stderr | grep -q "^test passed$" ||
  { echo "simulation did not pass" >&2; exit 1; }

// ==== tb_rab_core.sv ====
// random testbench for the remap address buffer core with a reference model of slices and misses
module tb_rab_core
  import rab_pkg::*;
;

  localparam int N_SLICES  = N_SLICES_DEF;
  localparam int MHF_DEPTH = MHF_DEPTH_DEF;
  localparam int N_REG_OPS = 40;
  localparam int N_REQS    = 200;
  localparam int N_REQS_B  = 50;
  localparam int N_OVF     = MHF_DEPTH + 3;
  // register ops, slice programming, request phases and miss drains
  localparam int N_TRANS = 2 * N_REG_OPS + 13 + 4 * N_SLICES + N_REQS + N_REQS_B + N_OVF
                           + 3 * (2 * MHF_DEPTH + 2);
  localparam int CYCLE_LIMIT = 4 * N_TRANS * 10;

  logic                Clk_CI;
  logic                Rst_RBI;
  logic [ADDR_W-1:0]   s_axi_awaddr_i;
  logic                s_axi_awvalid_i;
  logic                s_axi_awready_o;
  logic [ADDR_W-1:0]   s_axi_wdata_i;
  logic [ADDR_W/8-1:0] s_axi_wstrb_i;
  logic                s_axi_wvalid_i;
  logic                s_axi_wready_o;
  logic [1:0]          s_axi_bresp_o;
  logic                s_axi_bvalid_o;
  logic                s_axi_bready_i;
  logic [ADDR_W-1:0]   s_axi_araddr_i;
  logic                s_axi_arvalid_i;
  logic                s_axi_arready_o;
  logic [ADDR_W-1:0]   s_axi_rdata_o;
  logic [1:0]          s_axi_rresp_o;
  logic                s_axi_rvalid_o;
  logic                s_axi_rready_i;
  logic                req_valid_i;
  logic                req_ready_o;
  logic [ADDR_W-1:0]   req_addr_i;
  logic [7:0]          req_len_i;
  logic [SIZE_W-1:0]   req_size_i;
  logic                req_write_i;
  logic [ID_W-1:0]     req_id_i;
  logic                res_valid_o;
  logic                res_ready_i;
  result_e             res_kind_o;
  logic [ADDR_W-1:0]   res_addr_o;
  logic [ID_W-1:0]     res_id_o;
  logic                mhf_full_o;

  integer seed;
  int     cycle_cnt;

  // reference copy of the slice registers and the miss FIFO
  logic [31:0] m_start [N_SLICES];
  logic [31:0] m_end   [N_SLICES];
  logic [31:0] m_off   [N_SLICES];
  logic [2:0]  m_flags [N_SLICES];
  logic [31:0] miss_addr_q [$];
  logic [3:0]  miss_id_q [$];
  // expected content of the result register
  logic        m_valid;
  result_e     m_kind;
  logic [31:0] m_addr;
  logic [3:0]  m_id;

  rab_core #(.N_SLICES(N_SLICES), .MHF_DEPTH(MHF_DEPTH)) dut (
    .Clk_CI          (Clk_CI),
    .Rst_RBI         (Rst_RBI),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_addr_i      (req_addr_i),
    .req_len_i       (req_len_i),
    .req_size_i      (req_size_i),
    .req_write_i     (req_write_i),
    .req_id_i        (req_id_i),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_kind_o      (res_kind_o),
    .res_addr_o      (res_addr_o),
    .res_id_o        (res_id_o),
    .mhf_full_o      (mhf_full_o)
  );

  initial begin
    Clk_CI = 1'b0;
    forever #10 Clk_CI = ~Clk_CI;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge Clk_CI);
      cycle_cnt++;
    end
    $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("test failed");
    $fatal(1, "cycle limit reached");
  end

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("ERROR time=%0t signal=%s actual=0x%08h expected=0x%08h", $time, name, act, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic slice_addr(input logic [31:0] addr);
    return addr >= 32'h10 && addr < 32'h10 + 32'(N_SLICES) * 32'h10;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    int idx;
    idx = int'((addr - 32'h10) >> 4);
    case (addr[3:2])
      2'd0:    return m_start[idx];
      2'd1:    return m_end[idx];
      2'd2:    return m_off[idx];
      default: return {29'd0, m_flags[idx]};
    endcase
  endfunction

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] exp_resp);
    int hold;
    @(negedge Clk_CI);
    s_axi_awaddr_i  = addr;
    s_axi_wdata_i   = data;
    s_axi_wstrb_i   = strb;
    s_axi_awvalid_i = 1'b1;
    s_axi_wvalid_i  = 1'b1;
    // no response is pending, so address and data are taken at the next edge
    @(posedge Clk_CI);
    check("s_axi_awready_o", 32'(s_axi_awready_o), 32'd1);
    check("s_axi_wready_o", 32'(s_axi_wready_o), 32'd1);
    @(negedge Clk_CI);
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i  = 1'b0;
    check("s_axi_bvalid_o", 32'(s_axi_bvalid_o), 32'd1);
    check("s_axi_bresp_o", 32'(s_axi_bresp_o), 32'(exp_resp));
    hold = $random(seed) & 3;
    // response has to wait for bready
    repeat (hold) begin
      @(negedge Clk_CI);
      check("s_axi_bvalid_o", 32'(s_axi_bvalid_o), 32'd1);
    end
    s_axi_bready_i = 1'b1;
    @(negedge Clk_CI);
    s_axi_bready_i = 1'b0;
    check("s_axi_bvalid_o", 32'(s_axi_bvalid_o), 32'd0);
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    int hold;
    @(negedge Clk_CI);
    s_axi_araddr_i  = addr;
    s_axi_arvalid_i = 1'b1;
    // no read data is pending, so the address is taken at the next edge
    @(posedge Clk_CI);
    check("s_axi_arready_o", 32'(s_axi_arready_o), 32'd1);
    @(negedge Clk_CI);
    s_axi_arvalid_i = 1'b0;
    check("s_axi_rvalid_o", 32'(s_axi_rvalid_o), 32'd1);
    check("s_axi_rdata_o", s_axi_rdata_o, exp_data);
    check("s_axi_rresp_o", 32'(s_axi_rresp_o), 32'(exp_resp));
    hold = $random(seed) & 3;
    repeat (hold) begin
      @(negedge Clk_CI);
      check("s_axi_rvalid_o", 32'(s_axi_rvalid_o), 32'd1);
    end
    s_axi_rready_i = 1'b1;
    @(negedge Clk_CI);
    s_axi_rready_i = 1'b0;
    check("s_axi_rvalid_o", 32'(s_axi_rvalid_o), 32'd0);
  endtask

  // merges the strobed bytes into the model, then does the bus write
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] cur;
    int          idx;
    if (slice_addr(addr)) begin
      idx = int'((addr - 32'h10) >> 4);
      cur = model_word(addr);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          cur[8*b +: 8] = data[8*b +: 8];
        end
      end
      case (addr[3:2])
        2'd0:    m_start[idx] = cur;
        2'd1:    m_end[idx]   = cur;
        2'd2:    m_off[idx]   = cur;
        default: m_flags[idx] = cur[2:0];
      endcase
      axi_write(addr, data, strb, RESP_OKAY);
    end else begin
      axi_write(addr, data, strb, RESP_SLVERR);
    end
  endtask

  task automatic read_reg(input logic [31:0] addr);
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    exp_data = 32'd0;
    exp_resp = RESP_OKAY;
    if (slice_addr(addr)) begin
      exp_data = model_word(addr);
    end else if (addr == 32'h00) begin
      exp_data = {30'd0, miss_addr_q.size() == MHF_DEPTH, miss_addr_q.size() != 0};
    end else if (addr == 32'h04) begin
      if (miss_id_q.size() != 0) begin
        exp_data = 32'(miss_id_q[0]);
      end
    end else if (addr == 32'h08) begin
      // reading the miss address removes the oldest entry
      if (miss_addr_q.size() != 0) begin
        exp_data = miss_addr_q.pop_front();
        void'(miss_id_q.pop_front());
      end else begin
        exp_resp = RESP_SLVERR;
      end
    end else begin
      exp_resp = RESP_SLVERR;
    end
    axi_read(addr, exp_data, exp_resp);
  endtask

  task automatic program_slice(input int i, input logic [31:0] start, input logic [31:0] last,
                               input logic [31:0] off, input logic [2:0] flags);
    logic [31:0] base;
    base = 32'h10 + 32'(i) * 32'h10;
    write_reg(base, start, 4'hf);
    write_reg(base + 32'd4, last, 4'hf);
    write_reg(base + 32'd8, off, 4'hf);
    write_reg(base + 32'd12, {29'd0, flags}, 4'hf);
  endtask

  // sets the expected result of one accepted request
  task automatic predict(input logic [31:0] addr, input logic [7:0] len, input logic [2:0] size,
                         input logic wr, input logic [3:0] id);
    logic [31:0] aligned;
    logic [31:0] last;
    int          hit;
    hit     = -1;
    aligned = addr & ~((32'd1 << size) - 32'd1);
    last    = aligned + ((32'(len) + 32'd1) << size) - 32'd1;
    for (int i = N_SLICES - 1; i >= 0; i--) begin
      if (m_flags[i][FLAG_EN] && addr >= m_start[i] && last <= m_end[i]) begin
        hit = i;
      end
    end
    m_id   = id;
    m_addr = 32'd0;
    if (hit < 0) begin
      m_kind = RES_MISS;
      if (miss_addr_q.size() < MHF_DEPTH) begin
        miss_addr_q.push_back(addr);
        miss_id_q.push_back(id);
      end
    end else if (wr ? m_flags[hit][FLAG_WR] : m_flags[hit][FLAG_RD]) begin
      m_kind = RES_ACCEPT;
      m_addr = addr - m_start[hit] + m_off[hit];
    end else begin
      m_kind = RES_PROT;
    end
  endtask

  task automatic check_outputs();
    check("res_valid_o", 32'(res_valid_o), 32'(m_valid));
    check("req_ready_o", 32'(req_ready_o), 32'(!m_valid || res_ready_i));
    check("mhf_full_o", 32'(mhf_full_o), 32'(miss_addr_q.size() == MHF_DEPTH));
    if (m_valid) begin
      check("res_kind_o", 32'(res_kind_o), 32'(m_kind));
      check("res_id_o", 32'(res_id_o), 32'(m_id));
      if (m_kind == RES_ACCEPT) begin
        check("res_addr_o", res_addr_o, m_addr);
      end
    end
  endtask

  task automatic run_requests(input int n, input logic miss_only);
    int          issued;
    int          s;
    int          mode;
    logic        hs;
    logic [31:0] addr;
    issued = 0;
    while (issued < n || m_valid) begin
      @(negedge Clk_CI);
      check_outputs();
      res_ready_i = (($random(seed) & 3) != 0);
      req_valid_i = 1'b0;
      if (issued < n && ($random(seed) & 7) != 0) begin
        mode = $random(seed) & 7;
        s    = $random(seed) & 3;
        if (miss_only) begin
          addr = 32'h000f_0000 | (32'($random(seed)) & 32'hffff);
        end else if (mode < 5) begin
          addr = m_start[s] + (32'($random(seed)) & 32'h7fff);
        end else if (mode == 5) begin
          // close to the slice end, so longer bursts cross it
          addr = m_end[s] - (32'($random(seed)) & 32'h7f);
        end else begin
          addr = 32'($random(seed)) & 32'h000f_ffff;
        end
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_len_i   = 8'($random(seed) & 32'h0f);
        req_size_i  = 3'($random(seed) & 32'h3);
        req_write_i = 1'($random(seed) & 32'h1);
        req_id_i    = 4'($random(seed) & 32'hf);
      end
      hs = req_valid_i && (!m_valid || res_ready_i);
      if (hs) begin
        predict(req_addr_i, req_len_i, req_size_i, req_write_i, req_id_i);
        m_valid = 1'b1;
        issued++;
      end else if (res_ready_i) begin
        m_valid = 1'b0;
      end
    end
    @(negedge Clk_CI);
    check_outputs();
  endtask

  task automatic drain_misses();
    while (miss_addr_q.size() != 0) begin
      read_reg(32'h04);
      read_reg(32'h08);
    end
    read_reg(32'h08);
    read_reg(32'h00);
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] base;
    logic [2:0]  flags;
    seed            = 32'h8d9;
    Rst_RBI         = 1'b0;
    s_axi_awaddr_i  = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i   = '0;
    s_axi_wstrb_i   = '0;
    s_axi_wvalid_i  = 1'b0;
    s_axi_bready_i  = 1'b0;
    s_axi_araddr_i  = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i  = 1'b0;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    req_len_i       = '0;
    req_size_i      = '0;
    req_write_i     = 1'b0;
    req_id_i        = '0;
    res_ready_i     = 1'b0;
    m_valid         = 1'b0;
    m_kind          = RES_ACCEPT;
    m_addr          = '0;
    m_id            = '0;
    for (int i = 0; i < N_SLICES; i++) begin
      m_start[i] = '0;
      m_end[i]   = '0;
      m_off[i]   = '0;
      m_flags[i] = '0;
    end
    repeat (3) @(posedge Clk_CI);
    @(negedge Clk_CI);
    Rst_RBI = 1'b1;

    // slice words with random strobes, then the error cases
    for (int i = 0; i < N_REG_OPS; i++) begin
      addr = 32'h10 + (32'($random(seed)) & 32'h3c);
      write_reg(addr, 32'($random(seed)), 4'($random(seed) & 32'hf));
      read_reg(addr);
    end
    for (int i = 0; i < 4; i++) begin
      write_reg(32'(i) * 32'd4, 32'($random(seed)), 4'hf);
    end
    write_reg(32'h50, 32'h1234_5678, 4'hf);
    write_reg(32'h100, 32'h1234_5678, 4'hf);
    read_reg(32'h0c);
    read_reg(32'h50);
    read_reg(32'h00);
    read_reg(32'h04);
    read_reg(32'h08);

    // slice 1 overlaps slice 0, slice 2 is read only, slice 3 write only
    for (int i = 0; i < N_SLICES; i++) begin
      base  = (32'(i) << 17) | (32'($random(seed)) & 32'h0000_f000);
      flags = (i == 2) ? 3'b011 : ((i == 3) ? 3'b101 : 3'b111);
      if (i == 1) begin
        base = m_start[0] + 32'h4000;
      end
      program_slice(i, base, base + 32'h7fff, 32'($random(seed)), flags);
    end

    run_requests(N_REQS, 1'b0);
    drain_misses();
    // with slice 0 off the overlap goes to slice 1
    write_reg(32'h1c, 32'd0, 4'hf);
    run_requests(N_REQS_B, 1'b0);
    drain_misses();
    run_requests(N_OVF, 1'b1);
    read_reg(32'h00);
    drain_misses();

    $display("test passed");
    $finish;
  end

endmodule

// ==== rab_core_assert.sv ====
// bound handshake and reset assertions for one valid/ready channel of the address buffer
module rab_core_assert (
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic valid_i,
  input logic ready_i,
  input logic start_i
);

  // valid is cleared by reset
  assert property (@(posedge Clk_CI) !Rst_RBI |-> !valid_i)
    else $error("valid high during reset");

  // a valid waits for its ready
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) valid_i && !ready_i |=> valid_i)
    else $error("valid dropped before ready");

  // a response only rises one cycle after its request handshake
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) $rose(valid_i) |-> $past(start_i))
    else $error("valid rose without a handshake");

endmodule

bind rab_cfg_regs rab_core_assert u_bvalid_assert (
  .Clk_CI  (Clk_CI),
  .Rst_RBI (Rst_RBI),
  .valid_i (bvalid_q),
  .ready_i (s_axi_bready_i),
  .start_i (wr_hs)
);

bind rab_cfg_regs rab_core_assert u_rvalid_assert (
  .Clk_CI  (Clk_CI),
  .Rst_RBI (Rst_RBI),
  .valid_i (rvalid_q),
  .ready_i (s_axi_rready_i),
  .start_i (rd_hs)
);

bind rab_lookup rab_core_assert u_lookup_assert (
  .Clk_CI  (Clk_CI),
  .Rst_RBI (Rst_RBI),
  .valid_i (res_valid_q),
  .ready_i (res_ready_i),
  .start_i (req_hs)
);

// ==== rab_core.sv ====
// remap address buffer top level with the AXI4-Lite config port and the request port
module rab_core
  import rab_pkg::*;
#(
  parameter int N_SLICES  = N_SLICES_DEF,
  parameter int MHF_DEPTH = MHF_DEPTH_DEF
) (
  input  logic                Clk_CI,
  input  logic                Rst_RBI,
  input  logic [ADDR_W-1:0]   s_axi_awaddr_i,
  input  logic                s_axi_awvalid_i,
  output logic                s_axi_awready_o,
  input  logic [ADDR_W-1:0]   s_axi_wdata_i,
  input  logic [ADDR_W/8-1:0] s_axi_wstrb_i,
  input  logic                s_axi_wvalid_i,
  output logic                s_axi_wready_o,
  output logic [1:0]          s_axi_bresp_o,
  output logic                s_axi_bvalid_o,
  input  logic                s_axi_bready_i,
  input  logic [ADDR_W-1:0]   s_axi_araddr_i,
  input  logic                s_axi_arvalid_i,
  output logic                s_axi_arready_o,
  output logic [ADDR_W-1:0]   s_axi_rdata_o,
  output logic [1:0]          s_axi_rresp_o,
  output logic                s_axi_rvalid_o,
  input  logic                s_axi_rready_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic [ADDR_W-1:0]   req_addr_i,
  input  logic [7:0]          req_len_i,
  input  logic [SIZE_W-1:0]   req_size_i,
  input  logic                req_write_i,
  input  logic [ID_W-1:0]     req_id_i,
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output result_e             res_kind_o,
  output logic [ADDR_W-1:0]   res_addr_o,
  output logic [ID_W-1:0]     res_id_o,
  output logic                mhf_full_o
);

  slice_cfg_if #(.N_SLICES(N_SLICES)) cfg_if ();
  miss_push_if                        push_if ();
  miss_pop_if                         pop_if ();

  rab_lookup #(.N_SLICES(N_SLICES)) u_lookup (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_len_i   (req_len_i),
    .req_size_i  (req_size_i),
    .req_write_i (req_write_i),
    .req_id_i    (req_id_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_kind_o  (res_kind_o),
    .res_addr_o  (res_addr_o),
    .res_id_o    (res_id_o),
    .cfg         (cfg_if.lookup),
    .push        (push_if.lookup)
  );

  rab_miss_fifo #(.MHF_DEPTH(MHF_DEPTH)) u_miss_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push    (push_if.fifo),
    .pop     (pop_if.fifo)
  );

  rab_cfg_regs #(.N_SLICES(N_SLICES)) u_cfg_regs (
    .Clk_CI          (Clk_CI),
    .Rst_RBI         (Rst_RBI),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .cfg             (cfg_if.regs),
    .pop             (pop_if.regs)
  );

  // FIFO full level, takes the place of the miss FIFO interrupt
  assign mhf_full_o = push_if.full;

endmodule

// ==== rab_cfg_regs.sv ====
// AXI4-Lite register file for the slice configuration and the miss FIFO readout
module rab_cfg_regs
  import rab_pkg::*;
#(
  parameter int N_SLICES = N_SLICES_DEF
) (
  input  logic                Clk_CI,
  input  logic                Rst_RBI,
  input  logic [ADDR_W-1:0]   s_axi_awaddr_i,
  input  logic                s_axi_awvalid_i,
  output logic                s_axi_awready_o,
  input  logic [ADDR_W-1:0]   s_axi_wdata_i,
  input  logic [ADDR_W/8-1:0] s_axi_wstrb_i,
  input  logic                s_axi_wvalid_i,
  output logic                s_axi_wready_o,
  output logic [1:0]          s_axi_bresp_o,
  output logic                s_axi_bvalid_o,
  input  logic                s_axi_bready_i,
  input  logic [ADDR_W-1:0]   s_axi_araddr_i,
  input  logic                s_axi_arvalid_i,
  output logic                s_axi_arready_o,
  output logic [ADDR_W-1:0]   s_axi_rdata_o,
  output logic [1:0]          s_axi_rresp_o,
  output logic                s_axi_rvalid_o,
  input  logic                s_axi_rready_i,
  slice_cfg_if.regs           cfg,
  miss_pop_if.regs            pop
);

  slice_cfg_t [N_SLICES-1:0] slice_q;
  logic                      bvalid_q;
  logic [1:0]                bresp_q;
  logic                      rvalid_q;
  logic [1:0]                rresp_q;
  logic [ADDR_W-1:0]         rdata_q;

  logic                      wr_hs;
  logic                      rd_hs;
  logic [ADDR_W-1:0]         wr_merged;
  logic [ADDR_W-1:0]         rd_data;
  logic [1:0]                rd_resp;
  logic                      pop_req;

  function automatic logic slice_mapped(logic [ADDR_W-1:0] a);
    return (a >= REG_SLICE_BASE) &&
           (a < REG_SLICE_BASE + ADDR_W'(N_SLICES) * SLICE_STRIDE);
  endfunction

  function automatic int slice_idx(logic [ADDR_W-1:0] a);
    return int'((a - REG_SLICE_BASE) / SLICE_STRIDE);
  endfunction

  // word within a slice: start, end, offset, flags
  function automatic logic [ADDR_W-1:0] slice_word(slice_cfg_t s, logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] w;
    case (a[3:2])
      2'd0:    w = s.start_addr;
      2'd1:    w = s.end_addr;
      2'd2:    w = s.offset;
      default: w = {{(ADDR_W-3){1'b0}}, s.flags};
    endcase
    return w;
  endfunction

  // write only once both address and data are there and no response is pending
  assign wr_hs           = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_q;
  assign s_axi_awready_o = wr_hs;
  assign s_axi_wready_o  = wr_hs;

  always_comb begin
    wr_merged = '0;
    if (slice_mapped(s_axi_awaddr_i)) begin
      wr_merged = slice_word(slice_q[slice_idx(s_axi_awaddr_i)], s_axi_awaddr_i);
    end
    for (int b = 0; b < ADDR_W / 8; b++) begin
      if (s_axi_wstrb_i[b]) begin
        wr_merged[8*b +: 8] = s_axi_wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (Rst_RBI == 1'b0) begin
      slice_q  <= '0;
      bvalid_q <= 1'b0;
    end else if (wr_hs) begin
      bvalid_q <= 1'b1;
      if (slice_mapped(s_axi_awaddr_i)) begin
        case (s_axi_awaddr_i[3:2])
          2'd0:    slice_q[slice_idx(s_axi_awaddr_i)].start_addr <= wr_merged;
          2'd1:    slice_q[slice_idx(s_axi_awaddr_i)].end_addr   <= wr_merged;
          2'd2:    slice_q[slice_idx(s_axi_awaddr_i)].offset     <= wr_merged;
          default: slice_q[slice_idx(s_axi_awaddr_i)].flags      <= wr_merged[2:0];
        endcase
      end
    end else if (s_axi_bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  // status and miss registers are read only
  always_ff @(posedge Clk_CI) begin
    if (wr_hs) begin
      bresp_q <= slice_mapped(s_axi_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign rd_hs           = s_axi_arvalid_i & ~rvalid_q;
  assign s_axi_arready_o = rd_hs;

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    pop_req = 1'b0;
    if (slice_mapped(s_axi_araddr_i)) begin
      rd_data = slice_word(slice_q[slice_idx(s_axi_araddr_i)], s_axi_araddr_i);
    end else if (s_axi_araddr_i == REG_STATUS) begin
      rd_data = {{(ADDR_W-2){1'b0}}, pop.full, pop.not_empty};
    end else if (s_axi_araddr_i == REG_MISS_ID) begin
      // peek only, zero while empty
      rd_data = pop.not_empty ? ADDR_W'(pop.head_id) : '0;
    end else if (s_axi_araddr_i == REG_MISS_ADDR) begin
      if (pop.not_empty) begin
        rd_data = pop.head_addr;
        pop_req = rd_hs;
      end else begin
        rd_resp = RESP_SLVERR;
      end
    end else begin
      rd_resp = RESP_SLVERR;
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (Rst_RBI == 1'b0) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (s_axi_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (rd_hs) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign pop.pop        = pop_req;
  assign cfg.slices     = slice_q;
  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_bresp_o  = bresp_q;
  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rdata_o  = rdata_q;
  assign s_axi_rresp_o  = rresp_q;

endmodule

// ==== rab_miss_fifo.sv ====
// miss handling FIFO keeping address and ID of requests that found no slice
module rab_miss_fifo
  import rab_pkg::*;
#(
  parameter int MHF_DEPTH = MHF_DEPTH_DEF
) (
  input  logic        Clk_CI,
  input  logic        Rst_RBI,
  miss_push_if.fifo   push,
  miss_pop_if.fifo    pop
);

  localparam int PTR_W = (MHF_DEPTH > 1) ? $clog2(MHF_DEPTH) : 1;
  localparam int CNT_W = $clog2(MHF_DEPTH + 1);

  logic [ADDR_W-1:0] addr_mem [MHF_DEPTH];
  logic [ID_W-1:0]   id_mem   [MHF_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              full;
  logic              do_push;
  logic              do_pop;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == PTR_W'(MHF_DEPTH - 1)) ? '0 : p + PTR_W'(1);
  endfunction

  assign full    = (count_q == CNT_W'(MHF_DEPTH));
  assign do_push = push.valid & ~full;
  assign do_pop  = pop.pop & (count_q != '0);

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (Rst_RBI == 1'b0) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (do_push) begin
      addr_mem[wr_ptr_q] <= push.addr;
      id_mem[wr_ptr_q]   <= push.id;
    end
  end

  assign push.full     = full;
  assign pop.full      = full;
  assign pop.not_empty = (count_q != '0);
  assign pop.head_addr = addr_mem[rd_ptr_q];
  assign pop.head_id   = id_mem[rd_ptr_q];

endmodule

// ==== rab_lookup.sv ====
// request lookup: range check against all slices, address translation and result register
module rab_lookup
  import rab_pkg::*;
#(
  parameter int N_SLICES = N_SLICES_DEF
) (
  input  logic               Clk_CI,
  input  logic               Rst_RBI,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  logic [ADDR_W-1:0]  req_addr_i,
  input  logic [7:0]         req_len_i,
  input  logic [SIZE_W-1:0]  req_size_i,
  input  logic               req_write_i,
  input  logic [ID_W-1:0]    req_id_i,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output result_e            res_kind_o,
  output logic [ADDR_W-1:0]  res_addr_o,
  output logic [ID_W-1:0]    res_id_o,
  slice_cfg_if.lookup        cfg,
  miss_push_if.lookup        push
);

  logic [SIZE_W-1:0] size_mask;
  logic [ADDR_W-1:0] align_addr;
  logic [15:0]       burst_bytes;
  logic [ADDR_W-1:0] max_addr;
  logic              req_hs;
  logic              any_hit;
  slice_cfg_t        win_cfg;
  logic              allowed;
  result_e           kind;
  logic [ADDR_W-1:0] out_addr;

  logic              res_valid_q;
  result_e           res_kind_q;
  logic [ADDR_W-1:0] res_addr_q;
  logic [ID_W-1:0]   res_id_q;

  // a full result register stalls new requests
  assign req_ready_o = ~res_valid_q | res_ready_i;
  assign req_hs      = req_valid_i & req_ready_o;

  // align the start to the beat size before adding the burst length
  always_comb begin
    case (req_size_i)
      3'd1:    size_mask = 3'b110;
      3'd2:    size_mask = 3'b100;
      3'd3:    size_mask = 3'b000;
      default: size_mask = 3'b111;
    endcase
  end

  assign align_addr  = {req_addr_i[ADDR_W-1:SIZE_W], req_addr_i[SIZE_W-1:0] & size_mask};
  assign burst_bytes = ({8'd0, req_len_i} + 16'd1) << req_size_i;
  assign max_addr    = align_addr + ADDR_W'(burst_bytes) - ADDR_W'(1);

  // walk from the top so the lowest hitting slice is left in win_cfg
  always_comb begin
    any_hit = 1'b0;
    win_cfg = '0;
    for (int i = N_SLICES - 1; i >= 0; i--) begin
      if (cfg.slices[i].flags[FLAG_EN] &&
          req_addr_i >= cfg.slices[i].start_addr &&
          max_addr <= cfg.slices[i].end_addr) begin
        any_hit = 1'b1;
        win_cfg = cfg.slices[i];
      end
    end
  end

  assign allowed  = req_write_i ? win_cfg.flags[FLAG_WR] : win_cfg.flags[FLAG_RD];
  assign out_addr = req_addr_i - win_cfg.start_addr + win_cfg.offset;

  always_comb begin
    if (!any_hit) begin
      kind = RES_MISS;
    end else if (allowed) begin
      kind = RES_ACCEPT;
    end else begin
      kind = RES_PROT;
    end
  end

  // miss goes into the FIFO at the edge that registers the result
  assign push.valid = req_hs & ~any_hit;
  assign push.addr  = req_addr_i;
  assign push.id    = req_id_i;

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (Rst_RBI == 1'b0) begin
      res_valid_q <= 1'b0;
    end else if (req_hs) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (req_hs) begin
      res_kind_q <= kind;
      // translated address only for an accepted access, zero otherwise
      res_addr_q <= (kind == RES_ACCEPT) ? out_addr : '0;
      res_id_q   <= req_id_i;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_kind_o  = res_kind_q;
  assign res_addr_o  = res_addr_q;
  assign res_id_o    = res_id_q;

endmodule

// ==== rab_if.sv ====
// slice configuration, miss push and miss pop interfaces of the remap address buffer

interface slice_cfg_if
  import rab_pkg::*;
#(
  parameter int N_SLICES = N_SLICES_DEF
);
  // no handshake, the lookup sees a write from the next cycle
  slice_cfg_t [N_SLICES-1:0] slices;

  modport regs (output slices);
  modport lookup (input slices);
endinterface

interface miss_push_if
  import rab_pkg::*;
;
  logic              valid;
  logic [ADDR_W-1:0] addr;
  logic [ID_W-1:0]   id;
  // a push while full is dropped by the FIFO
  logic              full;

  modport lookup (output valid, output addr, output id);
  modport fifo (input valid, input addr, input id, output full);
endinterface

interface miss_pop_if
  import rab_pkg::*;
;
  logic              not_empty;
  logic [ADDR_W-1:0] head_addr;
  logic [ID_W-1:0]   head_id;
  logic              full;
  // only raised while not_empty is high
  logic              pop;

  modport fifo (
    output not_empty, output head_addr, output head_id, output full,
    input  pop
  );
  modport regs (
    input  not_empty, input head_addr, input head_id, input full,
    output pop
  );
endinterface

// ==== rab_pkg.sv ====
// remap address buffer package with widths, register map, slice type and result codes
package rab_pkg;

  // address and AXI4-Lite data width
  localparam int ADDR_W = 32;
  localparam int ID_W   = 4;
  // beat size field, up to 8 byte beats
  localparam int SIZE_W = 3;

  localparam int N_SLICES_DEF  = 4;
  localparam int MHF_DEPTH_DEF = 8;

  // register map, byte offsets
  localparam logic [ADDR_W-1:0] REG_STATUS     = 32'h00;
  localparam logic [ADDR_W-1:0] REG_MISS_ID    = 32'h04;
  localparam logic [ADDR_W-1:0] REG_MISS_ADDR  = 32'h08;
  localparam logic [ADDR_W-1:0] REG_SLICE_BASE = 32'h10;
  localparam logic [ADDR_W-1:0] SLICE_STRIDE   = 32'h10;

  // flag bit positions
  localparam int FLAG_EN = 0;
  localparam int FLAG_RD = 1;
  localparam int FLAG_WR = 2;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] end_addr;
    logic [ADDR_W-1:0] offset;
    logic [2:0]        flags;
  } slice_cfg_t;

  typedef enum logic [1:0] {
    RES_ACCEPT = 2'd0,
    RES_PROT   = 2'd1,
    RES_MISS   = 2'd2
  } result_e;

endpackage
